// File: bpu_defs.svh
`ifndef BPU_DEFS_SVH
`define BPU_DEFS_SVH

// program counter width
`define BPU_ADDR_W 32

// target table
`define BTB_ENTRIES 32
`define BTB_INDEX_W 5

// return address stack
`define RAS_DEPTH 8
`define RAS_PTR_W 3

// statistics counter width
`define STAT_W 32

`endif

// File: bpu_pkg.sv
package bpu_pkg;

`include "bpu_defs.svh"

    // fetch side lookup strobe
    typedef struct packed {
        logic                   en;
        logic [`BPU_ADDR_W-1:0] pc;
    } fetch_req_t;

    // answer, one cycle after the strobe
    typedef struct packed {
        logic                    valid;
        logic                    taken;
        logic [`BPU_ADDR_W-1:0]  target;
        logic [`BTB_INDEX_W-1:0] index;
    } bp_pred_t;

    // decode side command, strobes count only with operate_en
    typedef struct packed {
        logic                    operate_en;
        logic                    add_entry;
        logic                    delete_entry;
        logic                    resolve;
        logic                    push_ras;
        logic                    pop_ras;
        logic                    is_return;
        logic [`BPU_ADDR_W-1:0]  operate_pc;
        logic [`BTB_INDEX_W-1:0] operate_index;
        logic                    right_orien;
        logic                    target_error;
        logic [`BPU_ADDR_W-1:0]  right_target;
    } bp_update_t;

endpackage

// File: btb_table.sv
`timescale 1ns/1ps
`include "bpu_defs.svh"

module btb_table (
    input  logic                   aclk,
    input  logic                   reset,
    input  bpu_pkg::fetch_req_t    fetch,
    input  bpu_pkg::bp_update_t    update,
    input  logic [`BPU_ADDR_W-1:0] ras_top,
    output bpu_pkg::bp_pred_t      pred,
    output logic                   resolve_right
);
    import bpu_pkg::*;

    // entry state
    logic [`BTB_ENTRIES-1:0] entry_valid;
    logic [`BPU_ADDR_W-1:0]  entry_pc     [`BTB_ENTRIES];
    logic [`BPU_ADDR_W-1:0]  entry_target [`BTB_ENTRIES];
    logic                    entry_ret    [`BTB_ENTRIES];
    logic [1:0]              entry_cnt    [`BTB_ENTRIES];

    // round-robin allocation
    logic [`BTB_INDEX_W-1:0] alloc_ptr;

    // lookup
    logic                    hit;
    logic [`BTB_INDEX_W-1:0] hit_index;
    logic                    look_taken;
    logic [`BPU_ADDR_W-1:0]  look_target;

    // registered answer
    logic                    pred_valid_q;
    logic                    pred_taken_q;
    logic [`BPU_ADDR_W-1:0]  pred_target_q;
    logic [`BTB_INDEX_W-1:0] pred_index_q;

    // update decode
    logic                    do_add;
    logic                    do_delete;
    logic                    do_resolve;
    logic [1:0]              cnt_old;
    logic [1:0]              cnt_new;

    // lowest matching entry wins
    always_comb begin
        hit       = 1'b0;
        hit_index = '0;
        for (int i = `BTB_ENTRIES - 1; i >= 0; i--) begin
            if (entry_valid[i] && (entry_pc[i] == fetch.pc)) begin
                hit       = 1'b1;
                hit_index = `BTB_INDEX_W'(i);
            end
        end
    end

    assign look_taken = hit && entry_cnt[hit_index][1];

    always_comb begin
        if (!hit) begin
            look_target = '0;
        end else if (entry_ret[hit_index]) begin
            look_target = ras_top;
        end else begin
            look_target = entry_target[hit_index];
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            pred_valid_q <= 1'b0;
            pred_taken_q <= 1'b0;
        end else begin
            pred_valid_q <= fetch.en;
            pred_taken_q <= fetch.en && look_taken;
        end
    end

    always_ff @(posedge aclk) begin
        if (fetch.en) begin
            pred_target_q <= look_target;
            pred_index_q  <= hit_index;
        end
    end

    assign pred = '{
        valid:  pred_valid_q,
        taken:  pred_taken_q,
        target: pred_target_q,
        index:  pred_index_q
    };

    assign do_add     = update.operate_en && update.add_entry;
    assign do_delete  = update.operate_en && update.delete_entry;
    assign do_resolve = update.operate_en && update.resolve;

    assign cnt_old = entry_cnt[update.operate_index];

    // saturating 2-bit direction counter
    always_comb begin
        cnt_new = cnt_old;
        if (update.right_orien) begin
            if (cnt_old != 2'b11) begin
                cnt_new = cnt_old + 2'b01;
            end
        end else begin
            if (cnt_old != 2'b00) begin
                cnt_new = cnt_old - 2'b01;
            end
        end
    end

    // judged on the entry as it stood before this resolve
    assign resolve_right = entry_valid[update.operate_index]
                           && (cnt_old[1] == update.right_orien)
                           && !update.target_error;

    always_ff @(posedge aclk) begin
        if (reset) begin
            entry_valid <= '0;
            alloc_ptr   <= '0;
        end else begin
            if (do_delete) begin
                entry_valid[update.operate_index] <= 1'b0;
            end
            if (do_add) begin
                entry_valid[alloc_ptr] <= 1'b1;
                alloc_ptr              <= alloc_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (do_resolve) begin
            entry_cnt[update.operate_index] <= cnt_new;
            if (update.target_error) begin
                entry_target[update.operate_index] <= update.right_target;
            end
        end
        // new entry starts weakly taken
        if (do_add) begin
            entry_pc[alloc_ptr]     <= update.operate_pc;
            entry_target[alloc_ptr] <= update.right_target;
            entry_ret[alloc_ptr]    <= update.is_return;
            entry_cnt[alloc_ptr]    <= 2'b10;
        end
    end

endmodule

// File: ras_stack.sv
`timescale 1ns/1ps
`include "bpu_defs.svh"

module ras_stack (
    input  logic                   aclk,
    input  logic                   reset,
    input  logic                   push,
    input  logic                   pop,
    input  logic [`BPU_ADDR_W-1:0] push_pc,
    output logic [`BPU_ADDR_W-1:0] top
);
    import bpu_pkg::*;

    localparam int unsigned CNT_W = `RAS_PTR_W + 1;
    localparam logic [CNT_W-1:0] FULL = CNT_W'(`RAS_DEPTH);

    logic [`BPU_ADDR_W-1:0] slot [`RAS_DEPTH];

    // ptr is the next free slot, also the oldest one when full
    logic [`RAS_PTR_W-1:0]  ptr;
    logic [CNT_W-1:0]       count;

    logic                   pop_ok;
    logic [`RAS_PTR_W-1:0]  ptr_popped;
    logic [CNT_W-1:0]       count_popped;
    logic [`RAS_PTR_W-1:0]  top_ptr;

    assign top_ptr = ptr - 1'b1;
    assign top     = (count == '0) ? '0 : slot[top_ptr];

    // pop acts before a push in the same cycle
    assign pop_ok       = pop && (count != '0);
    assign ptr_popped   = pop_ok ? top_ptr : ptr;
    assign count_popped = pop_ok ? count - 1'b1 : count;

    always_ff @(posedge aclk) begin
        if (reset) begin
            ptr   <= '0;
            count <= '0;
        end else if (push) begin
            ptr   <= ptr_popped + 1'b1;
            count <= (count_popped == FULL) ? FULL : count_popped + 1'b1;
        end else begin
            ptr   <= ptr_popped;
            count <= count_popped;
        end
    end

    // return address is the call pc plus one instruction
    always_ff @(posedge aclk) begin
        if (push) begin
            slot[ptr_popped] <= push_pc + `BPU_ADDR_W'(4);
        end
    end

endmodule

// File: bp_stat_counter.sv
`timescale 1ns/1ps
`include "bpu_defs.svh"

module bp_stat_counter (
    input  logic               aclk,
    input  logic               reset,
    input  logic               resolve,
    input  logic               resolve_right,
    output logic [`STAT_W-1:0] resolved_count,
    output logic [`STAT_W-1:0] right_count,
    output logic [`STAT_W-1:0] error_count
);
    import bpu_pkg::*;

    logic [`STAT_W-1:0] resolved_q;
    logic [`STAT_W-1:0] right_q;
    logic [`STAT_W-1:0] error_q;

    // every resolve lands in exactly one of right or error
    always_ff @(posedge aclk) begin
        if (reset) begin
            resolved_q <= '0;
            right_q    <= '0;
            error_q    <= '0;
        end else if (resolve) begin
            resolved_q <= resolved_q + 1'b1;
            if (resolve_right) begin
                right_q <= right_q + 1'b1;
            end else begin
                error_q <= error_q + 1'b1;
            end
        end
    end

    assign resolved_count = resolved_q;
    assign right_count    = right_q;
    assign error_count    = error_q;

endmodule

// File: bpu_top.sv
`timescale 1ns/1ps
`include "bpu_defs.svh"

module bpu_top (
    input  logic                aclk,
    input  logic                reset,
    input  bpu_pkg::fetch_req_t fetch,
    input  bpu_pkg::bp_update_t update,
    output bpu_pkg::bp_pred_t   pred,
    output logic [`STAT_W-1:0]  resolved_count,
    output logic [`STAT_W-1:0]  right_count,
    output logic [`STAT_W-1:0]  error_count
);
    import bpu_pkg::*;

    logic [`BPU_ADDR_W-1:0] ras_top;
    logic                   resolve_right;
    logic                   ras_push;
    logic                   ras_pop;
    logic                   stat_resolve;

    // strobes only count with operate_en
    assign ras_push     = update.operate_en && update.push_ras;
    assign ras_pop      = update.operate_en && update.pop_ras;
    assign stat_resolve = update.operate_en && update.resolve;

    btb_table btb_table_i (
        .aclk          (aclk),
        .reset         (reset),
        .fetch         (fetch),
        .update        (update),
        .ras_top       (ras_top),
        .pred          (pred),
        .resolve_right (resolve_right)
    );

    ras_stack ras_stack_i (
        .aclk    (aclk),
        .reset   (reset),
        .push    (ras_push),
        .pop     (ras_pop),
        .push_pc (update.operate_pc),
        .top     (ras_top)
    );

    bp_stat_counter bp_stat_counter_i (
        .aclk           (aclk),
        .reset          (reset),
        .resolve        (stat_resolve),
        .resolve_right  (resolve_right),
        .resolved_count (resolved_count),
        .right_count    (right_count),
        .error_count    (error_count)
    );

endmodule

// File: bpu_top_props.sv
`timescale 1ns/1ps
`include "bpu_defs.svh"

module bpu_top_props (
    input logic                aclk,
    input logic                reset,
    input bpu_pkg::fetch_req_t fetch,
    input bpu_pkg::bp_pred_t   pred,
    input logic [`STAT_W-1:0]  resolved_count,
    input logic [`STAT_W-1:0]  right_count,
    input logic [`STAT_W-1:0]  error_count
);
    import bpu_pkg::*;

    // answer comes exactly one cycle after the strobe
    valid_after_fetch: assert property (
        @(posedge aclk) disable iff (reset)
        fetch.en |=> pred.valid
    ) else $error("prediction valid missing one cycle after a fetch strobe");

    no_valid_without_fetch: assert property (
        @(posedge aclk) disable iff (reset)
        !fetch.en |=> !pred.valid
    ) else $error("prediction valid raised without a fetch strobe");

    taken_needs_valid: assert property (
        @(posedge aclk) disable iff (reset)
        pred.taken |-> pred.valid
    ) else $error("taken high while prediction valid is low");

    // no disable here, this one is about reset itself
    clear_after_reset: assert property (
        @(posedge aclk)
        reset |=> (resolved_count == '0) && (right_count == '0)
                  && (error_count == '0) && !pred.valid
    ) else $error("counters or prediction not cleared after reset");

    // every resolve is either right or wrong
    count_balance: assert property (
        @(posedge aclk) disable iff (reset)
        resolved_count == right_count + error_count
    ) else $error("resolved count differs from right plus error counts");

endmodule

bind bpu_top bpu_top_props props_i (
    .aclk           (aclk),
    .reset          (reset),
    .fetch          (fetch),
    .pred           (pred),
    .resolved_count (resolved_count),
    .right_count    (right_count),
    .error_count    (error_count)
);

// File: tb_bpu_top.sv
`timescale 1ns/1ps
`include "bpu_defs.svh"

module tb_bpu_top;
    import bpu_pkg::*;

    // reset, then the six tests in order
    localparam int TEST_CYCLES = 11 + 1 + 7 + 8 + 4 + 26 + 4;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic               aclk;
    logic               reset;
    fetch_req_t         fetch;
    bp_update_t         update;
    bp_pred_t           pred;
    logic [`STAT_W-1:0] resolved_count;
    logic [`STAT_W-1:0] right_count;
    logic [`STAT_W-1:0] error_count;

    // expected state
    logic        m_valid  [`BTB_ENTRIES];
    logic [31:0] m_pc     [`BTB_ENTRIES];
    logic [31:0] m_target [`BTB_ENTRIES];
    logic        m_ret    [`BTB_ENTRIES];
    logic [1:0]  m_cnt    [`BTB_ENTRIES];
    int          m_alloc;
    logic [31:0] m_ras [$];
    int          m_resolved;
    int          m_right;
    int          m_error;

    logic [15:0] lfsr_state = 16'd45228;
    logic [31:0] pcs [3];
    logic [31:0] ret_pc;
    int          errors;
    int          checks;
    int          tests_run;
    int          test_err_start;
    int          cycle_count;

    bpu_top dut_i (
        .aclk           (aclk),
        .reset          (reset),
        .fetch          (fetch),
        .update         (update),
        .pred           (pred),
        .resolved_count (resolved_count),
        .right_count    (right_count),
        .error_count    (error_count)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // 16-bit fibonacci lfsr with taps 16 14 13 11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] w;
        logic        fb;
        w = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            w = {w[30:0], fb};
        end
        return w;
    endfunction

    // low two bits stay zero for word alignment
    function automatic logic [31:0] rand_pc();
        return rand_bits(30) << 2;
    endfunction

    function automatic logic [31:0] ras_top_model();
        return (m_ras.size() == 0) ? 32'h0 : m_ras[$];
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic apply_update(input bp_update_t u);
        update = u;
        @(negedge aclk);
        update = '0;
    endtask

    task automatic do_add(input logic [31:0] pc, input logic [31:0] target,
                          input logic is_ret);
        bp_update_t u;
        u = '0;
        u.operate_en   = 1'b1;
        u.add_entry    = 1'b1;
        u.operate_pc   = pc;
        u.right_target = target;
        u.is_return    = is_ret;
        m_valid[m_alloc]  = 1'b1;
        m_pc[m_alloc]     = pc;
        m_target[m_alloc] = target;
        m_ret[m_alloc]    = is_ret;
        m_cnt[m_alloc]    = 2'b10;
        m_alloc = (m_alloc + 1) % `BTB_ENTRIES;
        apply_update(u);
    endtask

    task automatic do_delete(input logic [4:0] idx);
        bp_update_t u;
        u = '0;
        u.operate_en    = 1'b1;
        u.delete_entry  = 1'b1;
        u.operate_index = idx;
        m_valid[idx] = 1'b0;
        apply_update(u);
    endtask

    task automatic do_resolve(input logic [4:0] idx, input logic dir,
                              input logic terr, input logic [31:0] new_target);
        bp_update_t u;
        logic       right;
        u = '0;
        u.operate_en    = 1'b1;
        u.resolve       = 1'b1;
        u.operate_index = idx;
        u.right_orien   = dir;
        u.target_error  = terr;
        u.right_target  = new_target;
        right = m_valid[idx] && (m_cnt[idx][1] == dir) && !terr;
        m_resolved++;
        if (right) begin
            m_right++;
        end else begin
            m_error++;
        end
        if (dir && m_cnt[idx] != 2'b11) begin
            m_cnt[idx] = m_cnt[idx] + 2'b01;
        end else if (!dir && m_cnt[idx] != 2'b00) begin
            m_cnt[idx] = m_cnt[idx] - 2'b01;
        end
        if (terr) begin
            m_target[idx] = new_target;
        end
        apply_update(u);
    endtask

    task automatic do_push(input logic [31:0] pc);
        bp_update_t u;
        u = '0;
        u.operate_en = 1'b1;
        u.push_ras   = 1'b1;
        u.operate_pc = pc;
        // full stack drops its oldest slot
        if (m_ras.size() == `RAS_DEPTH) begin
            void'(m_ras.pop_front());
        end
        m_ras.push_back(pc + 32'd4);
        apply_update(u);
    endtask

    task automatic do_pop();
        bp_update_t u;
        u = '0;
        u.operate_en = 1'b1;
        u.pop_ras    = 1'b1;
        if (m_ras.size() > 0) begin
            void'(m_ras.pop_back());
        end
        apply_update(u);
    endtask

    task automatic check_lookup(input logic [31:0] pc);
        logic                    exp_hit;
        logic                    exp_taken;
        logic [31:0]             exp_target;
        logic [`BTB_INDEX_W-1:0] exp_index;
        exp_hit    = 1'b0;
        exp_taken  = 1'b0;
        exp_target = '0;
        exp_index  = '0;
        for (int i = `BTB_ENTRIES - 1; i >= 0; i--) begin
            if (m_valid[i] && m_pc[i] == pc) begin
                exp_hit   = 1'b1;
                exp_index = `BTB_INDEX_W'(i);
            end
        end
        if (exp_hit) begin
            exp_taken  = m_cnt[exp_index][1];
            exp_target = m_ret[exp_index] ? ras_top_model() : m_target[exp_index];
        end
        fetch.en = 1'b1;
        fetch.pc = pc;
        @(negedge aclk);
        fetch = '0;
        check_value("pred valid", 32'(pred.valid), 32'd1);
        check_value("pred taken", 32'(pred.taken), 32'(exp_taken));
        check_value("pred target", pred.target, exp_target);
        check_value("pred index", 32'(pred.index), 32'(exp_index));
    endtask

    task automatic check_stats();
        check_value("resolved count", resolved_count, 32'(m_resolved));
        check_value("right count", right_count, 32'(m_right));
        check_value("error count", error_count, 32'(m_error));
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("test %0d %s finished with %0d errors", tests_run, name,
                 errors - test_err_start);
        test_err_start = errors;
    endtask

    initial begin
        fetch  = '0;
        update = '0;
        reset  = 1'b1;
        errors = 0;
        checks = 0;
        tests_run      = 0;
        test_err_start = 0;
        cycle_count    = 0;
        m_alloc    = 0;
        m_resolved = 0;
        m_right    = 0;
        m_error    = 0;
        for (int i = 0; i < `BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        repeat (10) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b0;

        check_lookup(rand_pc());
        check_stats();
        end_test("reset state");

        for (int i = 0; i < 3; i++) begin
            pcs[i] = rand_pc();
            do_add(pcs[i], rand_pc(), 1'b0);
        end
        for (int i = 0; i < 3; i++) begin
            check_lookup(pcs[i]);
        end
        check_lookup(rand_pc());
        end_test("allocation and hit");

        // counter walks down to 00 and back up to 10
        do_resolve(5'd0, 1'b0, 1'b0, 32'h0);
        do_resolve(5'd0, 1'b0, 1'b0, 32'h0);
        check_lookup(pcs[0]);
        do_resolve(5'd0, 1'b1, 1'b0, 32'h0);
        do_resolve(5'd0, 1'b1, 1'b0, 32'h0);
        check_lookup(pcs[0]);
        do_resolve(5'd0, 1'b1, 1'b1, rand_pc());
        check_lookup(pcs[0]);
        end_test("direction counter");

        do_delete(5'd1);
        for (int i = 0; i < 3; i++) begin
            check_lookup(pcs[i]);
        end
        end_test("delete");

        ret_pc = rand_pc();
        do_add(ret_pc, rand_pc(), 1'b1);
        do_push(rand_pc());
        do_push(rand_pc());
        check_lookup(ret_pc);
        do_pop();
        check_lookup(ret_pc);
        repeat (9) do_push(rand_pc());
        check_lookup(ret_pc);
        // eight pops empty it and the ninth hits an empty stack
        repeat (9) do_pop();
        check_lookup(ret_pc);
        end_test("return stack");

        do_resolve(5'd2, 1'b1, 1'b0, 32'h0);
        do_resolve(5'd2, 1'b1, 1'b0, 32'h0);
        do_resolve(5'd1, 1'b1, 1'b0, 32'h0);
        do_resolve(5'd3, 1'b0, 1'b0, 32'h0);
        check_stats();
        end_test("statistics");

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: bpu_top.f
+incdir+.
bpu_pkg.sv
btb_table.sv
ras_stack.sv
bp_stat_counter.sv
bpu_top.sv
bpu_top_props.sv
tb_bpu_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_bpu_top -f bpu_top.f \
    || { echo "verilator build failed"; exit 1; }

out=$(./obj_dir/Vtb_bpu_top)
echo "$out"
echo "$out" | grep -q "Simulation PASSED" && exit 0 || exit 1
